// File: logic/vga_pkg.sv
package vga_pkg;

    ////////////////////////////////
    // 800x600 at 60 Hz, 40 MHz pixel clock.
    ////////////////////////////////

    localparam int H_ACTIVE     = 800;
    localparam int H_SYNC_START = 840;   // after 40 px front porch.
    localparam int H_SYNC_END   = 968;   // 128 px sync pulse.
    localparam int H_TOTAL      = 1056;

    localparam int V_ACTIVE     = 600;
    localparam int V_SYNC_START = 601;
    localparam int V_SYNC_END   = 605;   // 4 line sync pulse.
    localparam int V_TOTAL      = 628;

    typedef logic [11:0] rgb_t;          // 4 bits per channel, r in the top nibble.

    // one pixel slot as it travels down the drawing chain.
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        rgb_t        rgb;
    } vga_bus_t;

endpackage

// File: logic/game_pkg.sv
package game_pkg;

    ////////////////////////////////
    // scene geometry and colours.
    ////////////////////////////////

    localparam int CAT_X = 1;
    localparam int CAT_Y = 430;
    localparam int CAT_W = 157;
    localparam int CAT_H = 99;

    localparam logic [11:0] CAT_KEY    = 12'h0F0;   // transparent sprite colour.
    localparam logic [11:0] SKY_RGB    = 12'h4AF;
    localparam logic [11:0] GROUND_RGB = 12'h3A3;
    localparam int          GROUND_Y   = 500;

    // flight length is THROW_BASE + power * THROW_STEP.
    localparam int THROW_BASE = 200;
    localparam int THROW_STEP = 2;

    typedef enum logic [1:0] {
        CAT_IDLE   = 2'b00,
        CAT_THROW1 = 2'b01,   // wind-up while the command is held.
        CAT_THROW2 = 2'b10    // flight.
    } cat_state_t;

    ////////////////////////////////
    // register map, byte addresses.
    ////////////////////////////////

    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_POWER  = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

// File: logic/vga_timing.sv
`timescale 1ns/1ps

module vga_timing
    import vga_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output vga_bus_t vga
);

    logic [10:0] hcnt;
    logic [10:0] vcnt;
    logic        line_end;
    logic        frame_end;

    assign line_end  = (hcnt == 11'(H_TOTAL - 1));
    assign frame_end = (vcnt == 11'(V_TOTAL - 1));

    ////////////////////////////////
    // free-running counters.
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (line_end) begin
            hcnt <= '0;
            if (frame_end) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 11'd1;
            end
        end else begin
            hcnt <= hcnt + 11'd1;
        end
    end

    ////////////////////////////////
    // syncs and blanking, registered together with the counts.
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            vga <= '0;
        end else begin
            vga.hcount <= hcnt;
            vga.vcount <= vcnt;
            vga.hsync  <= (hcnt >= 11'(H_SYNC_START)) && (hcnt < 11'(H_SYNC_END));
            vga.vsync  <= (vcnt >= 11'(V_SYNC_START)) && (vcnt < 11'(V_SYNC_END));
            vga.hblnk  <= (hcnt >= 11'(H_ACTIVE));
            vga.vblnk  <= (vcnt >= 11'(V_ACTIVE));
            vga.rgb    <= '0;   // colour is painted downstream.
        end
    end

endmodule

// File: logic/draw_background.sv
`timescale 1ns/1ps

module draw_background
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  vga_bus_t vga_in,
    output vga_bus_t vga_out
);

    rgb_t rgb_nxt;

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = '0;                        // black outside the visible area.
        end else if (vga_in.vcount >= 11'(GROUND_Y)) begin
            rgb_nxt = GROUND_RGB;
        end else begin
            rgb_nxt = SKY_RGB;
        end
    end

    // timing fields pass through one register untouched.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

// File: logic/cat_rom.sv
`timescale 1ns/1ps

module cat_rom
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic [13:0] addr,
    output rgb_t        rgb
);

    // stand-in image. every eighth pixel is see-through.
    always_comb begin
        if (addr[2:0] == 3'd0) begin
            rgb = CAT_KEY;
        end else begin
            rgb = addr[11:0];   // colour is just the low address bits.
        end
    end

endmodule

// File: logic/draw_player_cat.sv
`timescale 1ns/1ps

module draw_player_cat
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        turn_active,
    input  logic        throw_command,
    input  logic [7:0]  throw_power,

    input  rgb_t        rgb_cat,
    output logic [13:0] cat_addr,

    output cat_state_t  cat_state,
    output logic        throw_complete,

    input  vga_bus_t    vga_in,
    output vga_bus_t    vga_out
);

    vga_bus_t    vga_d;
    logic        inside_cat;
    logic [7:0]  rel_x;
    logic [6:0]  rel_y;

    cat_state_t  state;
    logic        cmd_prev;
    logic [11:0] throw_timer;
    logic [11:0] throw_limit;

    ////////////////////////////////
    // sprite overlay.
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_d <= '0;
        end else begin
            vga_d <= vga_in;
        end
    end

    assign inside_cat = (vga_d.hcount >= 11'(CAT_X)) &&
                        (vga_d.hcount <  11'(CAT_X + CAT_W)) &&
                        (vga_d.vcount >= 11'(CAT_Y)) &&
                        (vga_d.vcount <  11'(CAT_Y + CAT_H)) &&
                        !vga_d.hblnk && !vga_d.vblnk;

    assign rel_x = 8'(vga_d.hcount - 11'(CAT_X));
    assign rel_y = 7'(vga_d.vcount - 11'(CAT_Y));

    // row-major, one word per sprite pixel.
    assign cat_addr = 14'(rel_y) * 14'(CAT_W) + 14'(rel_x);

    always_comb begin
        vga_out = vga_d;
        if (inside_cat && (rgb_cat != CAT_KEY)) begin
            vga_out.rgb = rgb_cat;
        end
    end

    ////////////////////////////////
    // throw sequence.
    ////////////////////////////////

    // last timer value of the flight.
    assign throw_limit = 12'(THROW_BASE + 1) + 12'(throw_power) * 12'(THROW_STEP);

    assign throw_complete = (state == CAT_THROW2) && (throw_timer == throw_limit);
    assign cat_state      = state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= CAT_IDLE;
            cmd_prev    <= 1'b0;
            throw_timer <= '0;
        end else begin
            cmd_prev <= throw_command;
            case (state)
                CAT_IDLE: begin
                    // only a fresh press starts the wind-up.
                    if (turn_active && throw_command && !cmd_prev) begin
                        state <= CAT_THROW1;
                    end
                end
                CAT_THROW1: begin
                    if (!throw_command) begin   // release.
                        state       <= CAT_THROW2;
                        throw_timer <= '0;
                    end
                end
                CAT_THROW2: begin
                    if (throw_complete) begin
                        state <= CAT_IDLE;
                    end else begin
                        throw_timer <= throw_timer + 12'd1;
                    end
                end
                default: state <= CAT_IDLE;
            endcase
        end
    end

endmodule

// File: logic/wb_game_regs.sv
`timescale 1ns/1ps

module wb_game_regs
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,

    output logic        turn_active,
    output logic        throw_command,
    output logic [7:0]  throw_power,

    input  cat_state_t  cat_state,
    input  logic        throw_complete
);

    logic        valid;
    logic        access;
    logic        wr_en;
    logic [1:0]  ctrl_q;
    logic [7:0]  power_q;
    logic        throw_done;
    logic [31:0] rd_data;

    assign valid  = wb_req.cyc && wb_req.stb;
    assign access = valid && !wb_rsp.ack;   // one access per request.
    assign wr_en  = access && wb_req.we;

    ////////////////////////////////
    // registers.
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q  <= '0;
            power_q <= '0;
        end else if (wr_en) begin
            if (wb_req.adr == REG_CTRL) begin
                ctrl_q <= wb_req.dat_w[1:0];
            end
            if (wb_req.adr == REG_POWER) begin
                power_q <= wb_req.dat_w[7:0];
            end
        end
    end

    // sticky done flag. a new completion beats a clear.
    always_ff @(posedge clk) begin
        if (rst) begin
            throw_done <= 1'b0;
        end else if (throw_complete) begin
            throw_done <= 1'b1;
        end else if (wr_en && (wb_req.adr == REG_STATUS) && wb_req.dat_w[2]) begin
            throw_done <= 1'b0;
        end
    end

    assign turn_active   = ctrl_q[0];
    assign throw_command = ctrl_q[1];
    assign throw_power   = power_q;

    ////////////////////////////////
    // read path and ack.
    ////////////////////////////////

    always_comb begin
        case (wb_req.adr)
            REG_CTRL:   rd_data = {30'd0, ctrl_q};
            REG_POWER:  rd_data = {24'd0, power_q};
            REG_STATUS: rd_data = {29'd0, throw_done, cat_state};
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_rsp <= '0;
        end else begin
            wb_rsp.ack <= access;
            if (access) begin
                wb_rsp.dat_r <= rd_data;   // held until the next access.
            end
        end
    end

endmodule

// File: logic/cat_game_top.sv
`timescale 1ns/1ps

module cat_game_top
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output vga_bus_t vga_out
);

    vga_bus_t    vga_tim;
    vga_bus_t    vga_bg;

    logic [13:0] cat_addr;
    rgb_t        rgb_cat;

    logic        turn_active;
    logic        throw_command;
    logic [7:0]  throw_power;
    cat_state_t  cat_state;
    logic        throw_complete;

    ////////////////////////////////
    // pixel chain.
    ////////////////////////////////

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .vga (vga_tim)
    );

    draw_background u_draw_background (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_tim),
        .vga_out (vga_bg)
    );

    draw_player_cat u_draw_player_cat (
        .clk            (clk),
        .rst            (rst),
        .turn_active    (turn_active),
        .throw_command  (throw_command),
        .throw_power    (throw_power),
        .rgb_cat        (rgb_cat),
        .cat_addr       (cat_addr),
        .cat_state      (cat_state),
        .throw_complete (throw_complete),
        .vga_in         (vga_bg),
        .vga_out        (vga_out)
    );

    cat_rom u_cat_rom (
        .addr (cat_addr),
        .rgb  (rgb_cat)
    );

    // host side.
    wb_game_regs u_wb_game_regs (
        .clk            (clk),
        .rst            (rst),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .turn_active    (turn_active),
        .throw_command  (throw_command),
        .throw_power    (throw_power),
        .cat_state      (cat_state),
        .throw_complete (throw_complete)
    );

endmodule

// File: tests/cat_game_sva.sv
`timescale 1ns/1ps

module cat_game_sva
    import game_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input wb_req_t    wb_req,
    input wb_rsp_t    wb_rsp,
    input cat_state_t cat_state,
    input logic       throw_complete
);

    ////////////////////////////////
    // wishbone handshake.
    ////////////////////////////////

    ack_single : assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack lasted more than one cycle");

    ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack outside a valid bus cycle");

    ////////////////////////////////
    // throw sequence.
    ////////////////////////////////

    // the flight has already run at least one cycle when it completes.
    done_in_flight : assert property (@(posedge clk) disable iff (rst)
        throw_complete |-> $past(cat_state == CAT_THROW2))
        else $error("throw_complete without a preceding flight cycle");

    done_ends_flight : assert property (@(posedge clk) disable iff (rst)
        throw_complete |=> (cat_state == CAT_IDLE) && !throw_complete)
        else $error("flight did not end one cycle after throw_complete");

    no_skip : assert property (@(posedge clk) disable iff (rst)
        (cat_state == CAT_IDLE) |=> (cat_state != CAT_THROW2))
        else $error("state went from idle straight to flight");

endmodule

// the register slave sees the bus and the throw state, so one bind covers both.
bind wb_game_regs cat_game_sva cat_game_sva_i (
    .clk            (clk),
    .rst            (rst),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .cat_state      (cat_state),
    .throw_complete (throw_complete)
);

// File: tests/cat_game_tb.sv
`timescale 1ns/1ps

module cat_game_tb
    import vga_pkg::*;
    import game_pkg::*;
();

    // long enough for the register tests, two throws and the pixel scan.
    localparam int TIMEOUT_CYCLES = 3 * H_TOTAL * V_TOTAL + 2000;

    typedef logic [8*24-1:0] label_t;

    logic     clk;
    logic     rst;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    vga_bus_t vga_out;
    int       cycles = 0;

    cat_game_top cat_game_top_i (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .vga_out (vga_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "stopped at the first failure");
    endtask

    ////////////////////////////////
    // compare tasks.
    ////////////////////////////////

    task automatic compare_rgb(input label_t name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("MISMATCH %0s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_bus(input label_t name, input vga_bus_t exp,
                               input vga_bus_t act);
        if (act !== exp) begin
            $display("MISMATCH %0s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_word(input label_t name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %0s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_state(input label_t name, input cat_state_t exp,
                                 input cat_state_t act);
        if (act !== exp) begin
            $display("MISMATCH %0s expected %s actual %s", name, exp.name(), act.name());
            stop_run();
        end
    endtask

    ////////////////////////////////
    // wishbone master.
    ////////////////////////////////

    // request stays up until ack has been seen on a rising edge.
    task automatic bus_write(input logic [3:0] adr, input logic [31:0] data,
                             output int t_ack);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        @(negedge clk);
        if (!wb_rsp.ack) begin
            $display("no ack on the cycle after the write to address %h", adr);
            stop_run();
        end
        t_ack = cycles;
        @(negedge clk);
        if (wb_rsp.ack) begin
            $display("ack of the write to address %h lasted more than one cycle", adr);
            stop_run();
        end
        wb_req = '0;
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] data,
                            output int t_ack);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b0;
        wb_req.adr   = adr;
        wb_req.dat_w = '0;
        @(negedge clk);
        if (!wb_rsp.ack) begin
            $display("no ack on the cycle after the read of address %h", adr);
            stop_run();
        end
        data  = wb_rsp.dat_r;
        t_ack = cycles;
        @(negedge clk);
        if (wb_rsp.ack) begin
            $display("ack of the read of address %h lasted more than one cycle", adr);
            stop_run();
        end
        wb_req = '0;
    endtask

    ////////////////////////////////
    // scene and throw checks.
    ////////////////////////////////

    task automatic check_pixel(input label_t name, input int px, input int py, input rgb_t exp);
        vga_bus_t exp_bus;
        do begin
            @(negedge clk);
        end while (!((vga_out.hcount == 11'(px)) && (vga_out.vcount == 11'(py))));
        compare_rgb(name, exp, vga_out.rgb);
        // syncs and blanking follow the 800x600 timing at this coordinate.
        exp_bus.hcount = 11'(px);
        exp_bus.vcount = 11'(py);
        exp_bus.hsync  = (px >= H_SYNC_START) && (px < H_SYNC_END);
        exp_bus.vsync  = (py >= V_SYNC_START) && (py < V_SYNC_END);
        exp_bus.hblnk  = (px >= H_ACTIVE);
        exp_bus.vblnk  = (py >= V_ACTIVE);
        exp_bus.rgb    = exp;
        compare_bus(name, exp_bus, vga_out);
    endtask

    task automatic run_throw(input label_t name, input int power);
        logic [31:0] rd;
        logic [31:0] done_word;
        cat_state_t  st;
        int          t_upd;
        int          t_ack;
        int          flight_len;
        int          measured;
        flight_len = THROW_BASE + power * THROW_STEP + 3;   // counted from the release.
        bus_write(REG_POWER, 32'(power), t_ack);
        bus_write(REG_CTRL, 32'h1, t_ack);
        bus_write(REG_CTRL, 32'h3, t_ack);                  // press.
        bus_read(REG_STATUS, rd, t_ack);
        compare_state(name, CAT_THROW1, cat_state_t'(rd[1:0]));
        bus_write(REG_CTRL, 32'h1, t_upd);                  // release.
        bus_read(REG_STATUS, rd, t_ack);
        compare_state(name, CAT_THROW2, cat_state_t'(rd[1:0]));
        do begin
            bus_read(REG_STATUS, rd, t_ack);
            st = cat_state_t'(rd[1:0]);
        end while (st == CAT_THROW2);
        compare_state(name, CAT_IDLE, st);
        // status shows the state of the edge before the ack.
        measured = t_ack - 1 - t_upd;
        if ((measured < flight_len) || (measured > flight_len + 1)) begin
            $display("%0s left the flight after %0d cycles, expected %0d to %0d",
                     name, measured, flight_len, flight_len + 1);
            stop_run();
        end
        done_word    = '0;
        done_word[2] = 1'b1;
        done_word[1:0] = CAT_IDLE;
        compare_word(name, done_word, rd);
        bus_write(REG_CTRL, 32'h0, t_ack);                  // end of turn.
    endtask

    ////////////////////////////////
    // main sequence.
    ////////////////////////////////

    initial begin
        int              fd;
        int              n;
        int              px;
        int              py;
        int              t;
        logic            at_end;
        logic [31:0]     a;
        logic [31:0]     d;
        logic [31:0]     rd;
        logic [63:0]     cmd;
        label_t          name;
        logic [8*128-1:0] line;
        clk    = 1'b0;
        rst    = 1'b1;
        wb_req = '0;
        at_end = 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                $display("ack was high during reset");
                stop_run();
            end
        end
        rst = 1'b0;
        @(negedge clk);
        if (wb_rsp.ack) begin
            $display("ack was high right after reset");
            stop_run();
        end
        fd = $fopen("tests/cat_game_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            stop_run();
        end
        while (!at_end) begin
            cmd  = '0;
            name = '0;
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                at_end = 1'b1;
            end else if (cmd == 64'("#")) begin
                n = $fgets(line, fd);                       // comment line.
            end else if (cmd == 64'("WR")) begin
                n = $fscanf(fd, "%s %h %h", name, a, d);
                bus_write(4'(a), d, t);
            end else if (cmd == 64'("RD")) begin
                n = $fscanf(fd, "%s %h %h", name, a, d);
                bus_read(4'(a), rd, t);
                compare_word(name, d, rd);
            end else if (cmd == 64'("PIX")) begin
                n = $fscanf(fd, "%s %d %d %h", name, px, py, d);
                check_pixel(name, px, py, rgb_t'(d[11:0]));
            end else if (cmd == 64'("THROW")) begin
                n = $fscanf(fd, "%s %d", name, px);
                run_throw(name, px);
            end else begin
                $display("unknown command %0s in the stimulus file", cmd);
                stop_run();
            end
        end
        $fclose(fd);
        // black with vsync, then black with hsync in the vertical blank.
        check_pixel("vsync_line", 100, 602, 12'h000);
        check_pixel("hsync_in_vblank", 900, 610, 12'h000);
        $display("No errors");
        $finish;
    end

endmodule

// File: tests/cat_game_stimulus.txt
# command name operands, all hex except pixel coordinates and throw power
# WR name adr data | RD name adr expected | PIX name x y rgb | THROW name power
RD    status_reset     8 00000000
WR    ctrl_write       0 00000001
RD    ctrl_read        0 00000001
WR    power_write      4 000000a5
RD    power_read       4 000000a5
WR    gate_no_turn     0 00000002
RD    gate_no_turn_st  8 00000000
WR    gate_late_turn   0 00000003
RD    gate_late_st     8 00000000
WR    gate_release     0 00000000
RD    ctrl_cleared     0 00000000
THROW throw_power_0    0
WR    done_clear       8 00000004
RD    done_clear_st    8 00000000
THROW throw_power_100  100
WR    done_clear_2     8 00000004
RD    done_clear_2_st  8 00000000
PIX   sky_mid          400 100 4af
PIX   above_sprite     1 429 4af
PIX   left_of_tl       0 430 4af
PIX   corner_tl_key    1 430 4af
PIX   right_of_tl      2 430 001
PIX   key_in_sky       9 430 4af
PIX   corner_tr        157 430 09c
PIX   right_of_tr      158 430 4af
PIX   sprite_mid       80 480 ef9
PIX   key_in_ground    3 500 3a3
PIX   opaque_ground    4 500 af1
PIX   left_of_bl       0 528 3a3
PIX   corner_bl        1 528 c1a
PIX   corner_br        157 528 cb6
PIX   right_of_br      158 528 3a3
PIX   below_sprite     1 529 3a3
PIX   ground_mid       400 550 3a3
PIX   ground_last      799 599 3a3
RD    done_still_clear 8 00000000

// File: all.f
logic/vga_pkg.sv
logic/game_pkg.sv
logic/vga_timing.sv
logic/draw_background.sv
logic/cat_rom.sv
logic/draw_player_cat.sv
logic/wb_game_regs.sv
logic/cat_game_top.sv
tests/cat_game_sva.sv
tests/cat_game_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module cat_game_tb -f all.f -o sim
./obj_dir/sim
